//--- hdl/l1v_pkg.sv
package l1v_pkg;

    // Front side word and back side block
    localparam int ADDR_BITS   = 32;
    localparam int DATA_BITS   = 32;
    localparam int DATA_BYTES  = DATA_BITS / 8;
    localparam int BLOCK_BITS  = 128;
    localparam int OFFSET_BITS = $clog2(BLOCK_BITS / 8);

    // Geometry used when the top level is not overridden
    localparam int DEFAULT_WAYS = 4;
    localparam int DEFAULT_ROWS = 16;

    typedef logic [ADDR_BITS-1:0]  addr_t;
    typedef logic [DATA_BITS-1:0]  data_t;
    typedef logic [DATA_BYTES-1:0] mask_t;
    typedef logic [BLOCK_BITS-1:0] block_t;

    // Controller FSM
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_TAG_READ,
        ST_TAG_WAIT,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_FILL_REQ,
        ST_FILL_WAIT,
        ST_RESPOND
    } ctrl_state_e;

endpackage

//--- hdl/l1v_sram.sv
`timescale 1ns/1ps

module l1v_sram #(
    parameter int NUM_WAYS = l1v_pkg::DEFAULT_WAYS,
    parameter int NUM_ROWS = l1v_pkg::DEFAULT_ROWS,
    localparam int ROW_BITS = $clog2(NUM_ROWS),
    localparam int TAG_BITS = l1v_pkg::ADDR_BITS - ROW_BITS - l1v_pkg::OFFSET_BITS
) (
    input  logic                                    clk_i,
    input  logic                                    sram_rd_i,
    input  logic [ROW_BITS-1:0]                     sram_row_i,
    input  logic [NUM_WAYS-1:0]                     sram_we_i,
    input  logic [TAG_BITS-1:0]                     sram_wtag_i,
    input  l1v_pkg::block_t                         sram_wblock_i,
    output logic [NUM_WAYS*TAG_BITS-1:0]            sram_tags_o,
    output logic [NUM_WAYS*l1v_pkg::BLOCK_BITS-1:0] sram_blocks_o
);
    import l1v_pkg::*;

    // One tag bank and one block bank per way
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        logic [TAG_BITS-1:0] tag_mem [NUM_ROWS];
        block_t              block_mem [NUM_ROWS];
        logic [TAG_BITS-1:0] tag_q;
        block_t              block_q;

        always_ff @(posedge clk_i) begin
            if (sram_we_i[w]) begin
                tag_mem[sram_row_i]   <= sram_wtag_i;
                block_mem[sram_row_i] <= sram_wblock_i;
            end
            if (sram_rd_i) begin
                // Write first, so a fill is seen by the read in the same cycle
                if (sram_we_i[w]) begin
                    tag_q   <= sram_wtag_i;
                    block_q <= sram_wblock_i;
                end else begin
                    tag_q   <= tag_mem[sram_row_i];
                    block_q <= block_mem[sram_row_i];
                end
            end
        end

        assign sram_tags_o[w*TAG_BITS +: TAG_BITS]       = tag_q;
        assign sram_blocks_o[w*BLOCK_BITS +: BLOCK_BITS] = block_q;
    end

endmodule

//--- hdl/l1v_line_state.sv
`timescale 1ns/1ps

module l1v_line_state #(
    parameter int NUM_WAYS = l1v_pkg::DEFAULT_WAYS,
    parameter int NUM_ROWS = l1v_pkg::DEFAULT_ROWS,
    localparam int ROW_BITS = $clog2(NUM_ROWS),
    localparam int WAY_BITS = $clog2(NUM_WAYS)
) (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic [ROW_BITS-1:0] row_i,
    input  logic [WAY_BITS-1:0] way_i,
    input  logic                set_valid_i,
    input  logic                set_dirty_i,
    input  logic                clear_dirty_i,
    output logic [NUM_WAYS-1:0] valid_o,
    output logic [NUM_WAYS-1:0] dirty_o,
    output logic [WAY_BITS-1:0] victim_way_o
);

    logic [NUM_WAYS-1:0] valid_q [NUM_ROWS];
    logic [NUM_WAYS-1:0] dirty_q [NUM_ROWS];
    logic [WAY_BITS-1:0] rr_q;
    logic [WAY_BITS-1:0] free_way;
    logic                free_found;

    assign valid_o = valid_q[row_i];
    assign dirty_o = dirty_q[row_i];

    // Lowest invalid way wins, scanning down so way 0 ends last
    always_comb begin
        free_way   = '0;
        free_found = 1'b0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_o[w]) begin
                free_way   = WAY_BITS'(w);
                free_found = 1'b1;
            end
        end
    end

    assign victim_way_o = free_found ? free_way : rr_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                valid_q[r] <= '0;
                dirty_q[r] <= '0;
            end
            rr_q <= '0;
        end else begin
            // Free-running round robin over the ways
            rr_q <= (rr_q == WAY_BITS'(NUM_WAYS - 1)) ? '0 : rr_q + 1'b1;
            if (set_valid_i) begin
                valid_q[row_i][way_i] <= 1'b1;
            end
            if (set_dirty_i) begin
                dirty_q[row_i][way_i] <= 1'b1;
            end else if (clear_dirty_i) begin
                dirty_q[row_i][way_i] <= 1'b0;
            end
        end
    end

endmodule

//--- hdl/l1v_controller.sv
`timescale 1ns/1ps

module l1v_controller #(
    parameter int NUM_WAYS = l1v_pkg::DEFAULT_WAYS,
    parameter int NUM_ROWS = l1v_pkg::DEFAULT_ROWS,
    localparam int ROW_BITS = $clog2(NUM_ROWS),
    localparam int WAY_BITS = $clog2(NUM_WAYS),
    localparam int TAG_BITS = l1v_pkg::ADDR_BITS - ROW_BITS - l1v_pkg::OFFSET_BITS
) (
    input  logic                                    clk_i,
    input  logic                                    rstn_i,

    input  l1v_pkg::addr_t                          req_addr_i,
    input  logic                                    req_write_i,
    input  l1v_pkg::data_t                          req_data_i,
    input  l1v_pkg::mask_t                          req_mask_i,
    input  logic                                    req_valid_i,
    output logic                                    req_ready_o,

    output l1v_pkg::data_t                          resp_data_o,
    output logic                                    resp_valid_o,
    input  logic                                    resp_ready_i,

    output l1v_pkg::addr_t                          mem_req_addr_o,
    output logic                                    mem_req_write_o,
    output l1v_pkg::block_t                         mem_req_data_o,
    output logic                                    mem_req_valid_o,
    input  logic                                    mem_req_ready_i,
    input  l1v_pkg::block_t                         mem_resp_data_i,
    input  logic                                    mem_resp_valid_i,
    output logic                                    mem_resp_ready_o,

    output logic                                    sram_rd_o,
    output logic [ROW_BITS-1:0]                     sram_row_o,
    output logic [NUM_WAYS-1:0]                     sram_we_o,
    output logic [TAG_BITS-1:0]                     sram_wtag_o,
    output l1v_pkg::block_t                         sram_wblock_o,
    input  logic [NUM_WAYS*TAG_BITS-1:0]            sram_tags_i,
    input  logic [NUM_WAYS*l1v_pkg::BLOCK_BITS-1:0] sram_blocks_i,

    output logic [ROW_BITS-1:0]                     row_o,
    output logic [WAY_BITS-1:0]                     way_o,
    output logic                                    set_valid_o,
    output logic                                    set_dirty_o,
    output logic                                    clear_dirty_o,
    input  logic [NUM_WAYS-1:0]                     valid_i,
    input  logic [NUM_WAYS-1:0]                     dirty_i,
    input  logic [WAY_BITS-1:0]                     victim_way_i
);
    import l1v_pkg::*;

    localparam int BYTE_BITS = $clog2(DATA_BYTES);

    ctrl_state_e state_q;

    // Captured request
    addr_t req_addr_q;
    logic  req_write_q;
    data_t req_data_q;
    mask_t req_mask_q;

    logic                resp_valid_q;
    data_t               resp_data_q;
    logic                mem_req_valid_q;
    logic                mem_req_write_q;
    addr_t               mem_req_addr_q;
    block_t              mem_req_data_q;
    logic                mem_resp_ready_q;
    logic [WAY_BITS-1:0] victim_q;

    logic [TAG_BITS-1:0]          req_tag;
    logic [ROW_BITS-1:0]          req_row;
    logic [OFFSET_BITS-BYTE_BITS-1:0] word_sel;
    logic                hit;
    logic [WAY_BITS-1:0] hit_way;
    block_t              hit_block;
    block_t              merged_block;
    data_t               hit_word;
    logic                victim_dirty;
    addr_t               victim_addr;
    addr_t               fill_addr;
    logic                write_hit;
    logic                fill_done;
    logic [WAY_BITS-1:0] way_sel;

    assign req_tag  = req_addr_q[ADDR_BITS-1 -: TAG_BITS];
    assign req_row  = req_addr_q[OFFSET_BITS +: ROW_BITS];
    assign word_sel = req_addr_q[OFFSET_BITS-1:BYTE_BITS];

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid_i[w] && sram_tags_i[w*TAG_BITS +: TAG_BITS] == req_tag) begin
                hit     = 1'b1;
                hit_way = WAY_BITS'(w);
            end
        end
    end

    assign hit_block = sram_blocks_i[hit_way*BLOCK_BITS +: BLOCK_BITS];
    assign hit_word  = hit_block[word_sel*DATA_BITS +: DATA_BITS];

    // Byte merge of the write into the hit block
    always_comb begin
        merged_block = hit_block;
        for (int b = 0; b < DATA_BYTES; b++) begin
            if (req_mask_q[b]) begin
                merged_block[word_sel*DATA_BITS + b*8 +: 8] = req_data_q[b*8 +: 8];
            end
        end
    end

    assign victim_dirty = dirty_i[victim_way_i];
    assign victim_addr  = {sram_tags_i[victim_way_i*TAG_BITS +: TAG_BITS], req_row,
                           {OFFSET_BITS{1'b0}}};
    assign fill_addr    = {req_tag, req_row, {OFFSET_BITS{1'b0}}};

    assign write_hit = (state_q == ST_LOOKUP) && hit && req_write_q;
    assign fill_done = mem_resp_ready_q && mem_resp_valid_i;
    assign way_sel   = fill_done ? victim_q : hit_way;

    // SRAM and line state strobes
    assign sram_rd_o     = (state_q == ST_TAG_READ) || fill_done;
    assign sram_row_o    = req_row;
    assign sram_we_o     = (write_hit || fill_done) ? (NUM_WAYS'(1) << way_sel) : '0;
    assign sram_wtag_o   = req_tag;
    assign sram_wblock_o = fill_done ? mem_resp_data_i : merged_block;
    assign row_o         = req_row;
    assign way_o         = way_sel;
    assign set_valid_o   = fill_done;
    assign clear_dirty_o = fill_done;
    assign set_dirty_o   = write_hit;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q          <= ST_IDLE;
            resp_valid_q     <= 1'b0;
            mem_req_valid_q  <= 1'b0;
            mem_resp_ready_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req_valid_i) begin
                        state_q <= ST_TAG_READ;
                    end
                end
                ST_TAG_READ: state_q <= ST_TAG_WAIT;
                ST_TAG_WAIT: state_q <= ST_LOOKUP;
                ST_LOOKUP: begin
                    if (hit && req_write_q) begin
                        state_q <= ST_IDLE;
                    end else if (hit) begin
                        resp_valid_q <= 1'b1;
                        state_q      <= ST_RESPOND;
                    end else begin
                        mem_req_valid_q <= 1'b1;
                        state_q         <= victim_dirty ? ST_WRITEBACK : ST_FILL_REQ;
                    end
                end
                // Request valid stays high, the fill follows the write-back
                ST_WRITEBACK: begin
                    if (mem_req_ready_i) begin
                        state_q <= ST_FILL_REQ;
                    end
                end
                ST_FILL_REQ: begin
                    if (mem_req_ready_i) begin
                        mem_req_valid_q  <= 1'b0;
                        mem_resp_ready_q <= 1'b1;
                        state_q          <= ST_FILL_WAIT;
                    end
                end
                ST_FILL_WAIT: begin
                    if (fill_done) begin
                        mem_resp_ready_q <= 1'b0;
                        state_q          <= ST_LOOKUP;
                    end
                end
                ST_RESPOND: begin
                    if (resp_ready_i) begin
                        resp_valid_q <= 1'b0;
                        state_q      <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_ready_o && req_valid_i) begin
            req_addr_q  <= req_addr_i;
            req_write_q <= req_write_i;
            req_data_q  <= req_data_i;
            req_mask_q  <= req_mask_i;
        end
        if (state_q == ST_LOOKUP) begin
            resp_data_q     <= hit_word;
            victim_q        <= victim_way_i;
            mem_req_write_q <= victim_dirty;
            mem_req_addr_q  <= victim_dirty ? victim_addr : fill_addr;
            mem_req_data_q  <= sram_blocks_i[victim_way_i*BLOCK_BITS +: BLOCK_BITS];
        end
        if (state_q == ST_WRITEBACK && mem_req_ready_i) begin
            mem_req_write_q <= 1'b0;
            mem_req_addr_q  <= fill_addr;
        end
    end

    assign req_ready_o      = (state_q == ST_IDLE);
    assign resp_valid_o     = resp_valid_q;
    assign resp_data_o      = resp_data_q;
    assign mem_req_valid_o  = mem_req_valid_q;
    assign mem_req_write_o  = mem_req_write_q;
    assign mem_req_addr_o   = mem_req_addr_q;
    assign mem_req_data_o   = mem_req_data_q;
    assign mem_resp_ready_o = mem_resp_ready_q;

endmodule

//--- hdl/l1v_top.sv
`timescale 1ns/1ps

module l1v_top #(
    parameter int NUM_WAYS = l1v_pkg::DEFAULT_WAYS,
    parameter int NUM_ROWS = l1v_pkg::DEFAULT_ROWS
) (
    input  logic            clk_i,
    input  logic            rstn_i,

    input  l1v_pkg::addr_t  req_addr_i,
    input  logic            req_write_i,
    input  l1v_pkg::data_t  req_data_i,
    input  l1v_pkg::mask_t  req_mask_i,
    input  logic            req_valid_i,
    output logic            req_ready_o,

    output l1v_pkg::data_t  resp_data_o,
    output logic            resp_valid_o,
    input  logic            resp_ready_i,

    output l1v_pkg::addr_t  mem_req_addr_o,
    output logic            mem_req_write_o,
    output l1v_pkg::block_t mem_req_data_o,
    output logic            mem_req_valid_o,
    input  logic            mem_req_ready_i,
    input  l1v_pkg::block_t mem_resp_data_i,
    input  logic            mem_resp_valid_i,
    output logic            mem_resp_ready_o
);
    import l1v_pkg::*;

    localparam int ROW_BITS = $clog2(NUM_ROWS);
    localparam int WAY_BITS = $clog2(NUM_WAYS);
    localparam int TAG_BITS = ADDR_BITS - ROW_BITS - OFFSET_BITS;

    logic                           sram_rd;
    logic [ROW_BITS-1:0]            sram_row;
    logic [NUM_WAYS-1:0]            sram_we;
    logic [TAG_BITS-1:0]            sram_wtag;
    block_t                         sram_wblock;
    logic [NUM_WAYS*TAG_BITS-1:0]   sram_tags;
    logic [NUM_WAYS*BLOCK_BITS-1:0] sram_blocks;

    logic [ROW_BITS-1:0] ls_row;
    logic [WAY_BITS-1:0] ls_way;
    logic                ls_set_valid;
    logic                ls_set_dirty;
    logic                ls_clear_dirty;
    logic [NUM_WAYS-1:0] ls_valid;
    logic [NUM_WAYS-1:0] ls_dirty;
    logic [WAY_BITS-1:0] ls_victim_way;

    l1v_controller #(
        .NUM_WAYS (NUM_WAYS),
        .NUM_ROWS (NUM_ROWS)
    ) i_controller (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .req_addr_i       (req_addr_i),
        .req_write_i      (req_write_i),
        .req_data_i       (req_data_i),
        .req_mask_i       (req_mask_i),
        .req_valid_i      (req_valid_i),
        .req_ready_o      (req_ready_o),
        .resp_data_o      (resp_data_o),
        .resp_valid_o     (resp_valid_o),
        .resp_ready_i     (resp_ready_i),
        .mem_req_addr_o   (mem_req_addr_o),
        .mem_req_write_o  (mem_req_write_o),
        .mem_req_data_o   (mem_req_data_o),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_resp_data_i  (mem_resp_data_i),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_ready_o (mem_resp_ready_o),
        .sram_rd_o        (sram_rd),
        .sram_row_o       (sram_row),
        .sram_we_o        (sram_we),
        .sram_wtag_o      (sram_wtag),
        .sram_wblock_o    (sram_wblock),
        .sram_tags_i      (sram_tags),
        .sram_blocks_i    (sram_blocks),
        .row_o            (ls_row),
        .way_o            (ls_way),
        .set_valid_o      (ls_set_valid),
        .set_dirty_o      (ls_set_dirty),
        .clear_dirty_o    (ls_clear_dirty),
        .valid_i          (ls_valid),
        .dirty_i          (ls_dirty),
        .victim_way_i     (ls_victim_way)
    );

    l1v_sram #(
        .NUM_WAYS (NUM_WAYS),
        .NUM_ROWS (NUM_ROWS)
    ) i_sram (
        .clk_i         (clk_i),
        .sram_rd_i     (sram_rd),
        .sram_row_i    (sram_row),
        .sram_we_i     (sram_we),
        .sram_wtag_i   (sram_wtag),
        .sram_wblock_i (sram_wblock),
        .sram_tags_o   (sram_tags),
        .sram_blocks_o (sram_blocks)
    );

    l1v_line_state #(
        .NUM_WAYS (NUM_WAYS),
        .NUM_ROWS (NUM_ROWS)
    ) i_line_state (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .row_i         (ls_row),
        .way_i         (ls_way),
        .set_valid_i   (ls_set_valid),
        .set_dirty_i   (ls_set_dirty),
        .clear_dirty_i (ls_clear_dirty),
        .valid_o       (ls_valid),
        .dirty_o       (ls_dirty),
        .victim_way_o  (ls_victim_way)
    );

endmodule

//--- tests/tb_l1v.sv
`timescale 1ns/1ps

module tb_l1v;
    import l1v_pkg::*;

    localparam int NUM_WAYS = 4;
    localparam int NUM_ROWS = 16;
    localparam int FIRST_READS = 24;
    localparam int RANDOM_OPS = 300;
    localparam int WB_TAGS = NUM_WAYS + 3;
    localparam int LATENCY_PAIRS = 20;
    localparam int STALL_READS = 60;
    localparam int TOTAL_REQUESTS = FIRST_READS + RANDOM_OPS + 2 * WB_TAGS
                                    + 2 * LATENCY_PAIRS + STALL_READS;

    logic   clk = 1'b0;
    logic   rstn;
    addr_t  req_addr;
    logic   req_write;
    data_t  req_data;
    mask_t  req_mask;
    logic   req_valid;
    logic   req_ready;
    data_t  resp_data;
    logic   resp_valid;
    logic   resp_ready;
    addr_t  mem_req_addr;
    logic   mem_req_write;
    block_t mem_req_data;
    logic   mem_req_valid;
    logic   mem_req_ready;
    block_t mem_resp_data;
    logic   mem_resp_valid;
    logic   mem_resp_ready;

    // Reference byte map and backing memory, both lazily filled
    logic [7:0] ref_mem [addr_t];
    block_t     mem_store [addr_t];

    int error_count = 0;
    int test_start_errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int writebacks = 0;

    always #2 clk = ~clk;

    l1v_top #(
        .NUM_WAYS (NUM_WAYS),
        .NUM_ROWS (NUM_ROWS)
    ) i_dut (
        .clk_i            (clk),
        .rstn_i           (rstn),
        .req_addr_i       (req_addr),
        .req_write_i      (req_write),
        .req_data_i       (req_data),
        .req_mask_i       (req_mask),
        .req_valid_i      (req_valid),
        .req_ready_o      (req_ready),
        .resp_data_o      (resp_data),
        .resp_valid_o     (resp_valid),
        .resp_ready_i     (resp_ready),
        .mem_req_addr_o   (mem_req_addr),
        .mem_req_write_o  (mem_req_write),
        .mem_req_data_o   (mem_req_data),
        .mem_req_valid_o  (mem_req_valid),
        .mem_req_ready_i  (mem_req_ready),
        .mem_resp_data_i  (mem_resp_data),
        .mem_resp_valid_i (mem_resp_valid),
        .mem_resp_ready_o (mem_resp_ready)
    );

    task automatic value_error(string signal, logic [127:0] expected, logic [127:0] actual);
        $display("FAILED at %0t ns: %s expected %0h, got %0h", $time, signal, expected, actual);
        error_count++;
    endtask

    task automatic report_problem(string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic finish_test(string name);
        if (error_count == test_start_errors) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, error_count - test_start_errors);
        end
        test_start_errors = error_count;
    endtask

    // Contents of never-written memory
    function automatic data_t init_word(addr_t a);
        return {a[31:2], 2'b00} ^ 32'ha5a5a5a5;
    endfunction

    function automatic logic [7:0] ref_byte(addr_t a);
        data_t w;
        w = init_word(a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return w[8*a[1:0] +: 8];
    endfunction

    function automatic data_t ref_word(addr_t a);
        data_t w;
        for (int b = 0; b < DATA_BYTES; b++) begin
            w[b*8 +: 8] = ref_byte({a[31:2], 2'(b)});
        end
        return w;
    endfunction

    function automatic block_t ref_block(addr_t a);
        block_t blk;
        for (int k = 0; k < 4; k++) begin
            blk[k*DATA_BITS +: DATA_BITS] = ref_word({a[31:4], 2'(k), 2'b00});
        end
        return blk;
    endfunction

    function automatic void ref_write(addr_t a, data_t d, mask_t m);
        for (int b = 0; b < DATA_BYTES; b++) begin
            if (m[b]) begin
                ref_mem[{a[31:2], 2'(b)}] = d[b*8 +: 8];
            end
        end
    endfunction

    function automatic block_t mem_block(addr_t a);
        block_t blk;
        if (mem_store.exists(a)) begin
            return mem_store[a];
        end
        for (int k = 0; k < 4; k++) begin
            blk[k*DATA_BITS +: DATA_BITS] = init_word({a[31:4], 2'(k), 2'b00});
        end
        return blk;
    endfunction

    // Tag goes above bit 16, row and word come from small ranges
    function automatic addr_t pool_addr(int tag, int row, int word);
        return (addr_t'(tag) << 16) | (addr_t'(row) << 4) | (addr_t'(word) << 2);
    endfunction

    // Memory bus model with random ready and response delays
    initial begin : memory_model
        int     req_delay;
        int     fill_delay;
        bit     fill_pending;
        addr_t  cap_addr;
        logic   cap_write;
        block_t cap_data;
        addr_t  fill_addr;
        req_delay = -1;
        fill_delay = 0;
        fill_pending = 1'b0;
        mem_req_ready = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_data = '0;
        forever begin
            @(posedge clk);
            #1;
            mem_resp_valid = 1'b0;
            if (mem_req_ready) begin
                mem_req_ready = 1'b0;
                if (cap_addr[3:0] != 4'h0) begin
                    report_problem("memory request address is not block aligned");
                end
                if (cap_write) begin
                    writebacks++;
                    if (cap_data !== ref_block(cap_addr)) begin
                        value_error("mem_req_data_o", ref_block(cap_addr), cap_data);
                    end
                    mem_store[cap_addr] = cap_data;
                end else begin
                    fill_addr = cap_addr;
                    fill_delay = int'($urandom_range(0, 5));
                    fill_pending = 1'b1;
                end
            end
            if (fill_pending && mem_resp_ready) begin
                if (fill_delay == 0) begin
                    mem_resp_data = mem_block(fill_addr);
                    mem_resp_valid = 1'b1;
                    fill_pending = 1'b0;
                end else begin
                    fill_delay--;
                end
            end
            if (mem_req_valid) begin
                if (req_delay < 0) begin
                    req_delay = int'($urandom_range(0, 5));
                end
                if (req_delay == 0) begin
                    mem_req_ready = 1'b1;
                    cap_addr = mem_req_addr;
                    cap_write = mem_req_write;
                    cap_data = mem_req_data;
                    req_delay = -1;
                end else begin
                    req_delay--;
                end
            end
        end
    end

    task automatic do_request(input addr_t addr, input logic write, input data_t data,
                              input mask_t mask, input bit stall, output int latency);
        data_t expected;
        data_t held;
        latency = 0;
        while (!req_ready) begin
            @(posedge clk);
            #1;
            if (resp_valid) begin
                report_problem("response raised while no read was pending");
            end
        end
        req_addr = addr;
        req_write = write;
        req_data = data;
        req_mask = mask;
        req_valid = 1'b1;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        if (write) begin
            ref_write(addr, data, mask);
            return;
        end
        expected = ref_word(addr);
        while (!resp_valid) begin
            @(posedge clk);
            #1;
            latency++;
        end
        held = resp_data;
        if (resp_data !== expected) begin
            value_error("resp_data_o", 128'(expected), 128'(resp_data));
        end
        resp_ready = stall ? ($urandom_range(0, 2) == 0) : 1'b1;
        while (!resp_ready) begin
            @(posedge clk);
            #1;
            if (!resp_valid) begin
                report_problem("resp_valid_o dropped before the response was taken");
            end
            if (resp_data !== held) begin
                value_error("resp_data_o", 128'(held), 128'(resp_data));
            end
            if (req_ready) begin
                report_problem("req_ready_o rose while a response was pending");
            end
            resp_ready = ($urandom_range(0, 2) == 0);
        end
        @(posedge clk);
        #1;
        resp_ready = 1'b1;
        if (resp_valid || !req_ready) begin
            report_problem("controller did not return to idle after the response");
        end
    endtask

    initial begin : stimulus
        int    lat;
        int    wb_before;
        addr_t a;
        void'($urandom(32'h3275d73d));
        rstn = 1'b0;
        req_addr = '0;
        req_write = 1'b0;
        req_data = '0;
        req_mask = '0;
        req_valid = 1'b0;
        resp_ready = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;

        if (req_ready !== 1'b1) value_error("req_ready_o", 128'(1), 128'(req_ready));
        if (resp_valid !== 1'b0) value_error("resp_valid_o", 128'(0), 128'(resp_valid));
        if (mem_req_valid !== 1'b0) value_error("mem_req_valid_o", 128'(0), 128'(mem_req_valid));
        finish_test("reset_state");

        for (int i = 0; i < FIRST_READS; i++) begin
            do_request(pool_addr(i % 6, (i / 6) % 4, i % 4), 1'b0, '0, '0, 1'b0, lat);
        end
        finish_test("first_reads");

        for (int i = 0; i < RANDOM_OPS; i++) begin
            a = pool_addr(int'($urandom_range(0, 5)), int'($urandom_range(0, 3)),
                          int'($urandom_range(0, 3)));
            do_request(a, 1'($urandom_range(0, 1)), $urandom(), mask_t'($urandom_range(1, 15)),
                       1'b0, lat);
        end
        finish_test("random_traffic");

        // More dirty tags than ways in row 9
        wb_before = writebacks;
        for (int t = 0; t < WB_TAGS; t++) begin
            do_request(pool_addr(8 + t, 9, t % 4), 1'b1, $urandom(),
                       mask_t'($urandom_range(1, 15)), 1'b0, lat);
        end
        for (int t = 0; t < WB_TAGS; t++) begin
            do_request(pool_addr(8 + t, 9, t % 4), 1'b0, '0, '0, 1'b0, lat);
        end
        if (writebacks == wb_before) begin
            report_problem("no write-back reached memory after overfilling a row");
        end
        finish_test("write_back");

        for (int i = 0; i < LATENCY_PAIRS; i++) begin
            a = pool_addr(int'($urandom_range(0, 5)), int'($urandom_range(0, 3)),
                          int'($urandom_range(0, 3)));
            do_request(a, 1'b0, '0, '0, 1'b0, lat);
            do_request(a, 1'b0, '0, '0, 1'b0, lat);
            if (lat != 3) value_error("resp_valid_o latency", 128'(3), 128'(lat));
        end
        finish_test("hit_latency");

        for (int i = 0; i < STALL_READS; i++) begin
            a = pool_addr(int'($urandom_range(0, 5)), int'($urandom_range(0, 3)),
                          int'($urandom_range(0, 3)));
            do_request(a, 1'b0, '0, '0, 1'b1, lat);
        end
        finish_test("response_backpressure");

        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (TOTAL_REQUESTS * 200 + 20) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", TOTAL_REQUESTS * 200 + 20);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- compile.f
hdl/l1v_pkg.sv
hdl/l1v_sram.sv
hdl/l1v_line_state.sv
hdl/l1v_controller.sv
hdl/l1v_top.sv
tests/tb_l1v.sv

//--- run.sh
#!/usr/bin/env bash
# Build the L1 cache testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_l1v -f compile.f -o tb_l1v_sim \
    && sim_out="$(./obj_dir/tb_l1v_sim)" \
    || { echo "Build or simulation run failed"; exit 1; }

echo "$sim_out"
echo "$sim_out" | grep -qx "RESULT: PASS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
